/* src/tlp_pkg.sv */
// TLP definitions for the MMIO tie-off endpoint
// Header field positions, format codes, register map constants and
// the decoded read request carried between the blocks

`default_nettype none

package tlp_pkg;

    // Bus and field widths
    typedef logic [255:0] tlp_data_t;
    typedef logic [31:0]  tlp_keep_t;
    typedef logic [127:0] tlp_hdr_t;
    typedef logic [63:0]  reg_data_t;

    typedef logic [7:0]   fmt_type_t;
    typedef logic [9:0]   tlp_len_t;
    typedef logic [15:0]  req_id_t;
    typedef logic [9:0]   tlp_tag_t;
    typedef logic [2:0]   tc_t;
    typedef logic [2:0]   pf_num_t;
    typedef logic [7:0]   vf_num_t;
    typedef logic [11:0]  byte_count_t;
    typedef logic [6:0]   low_addr_t;

    // Request header field positions (low bit of each field)
    localparam int HDR_FMT_TYPE_LSB   = 24;
    localparam int HDR_LEN_LSB        = 0;
    localparam int HDR_TC_LSB         = 20;
    localparam int HDR_REQ_ID_LSB     = 48;
    localparam int HDR_TAG_LSB        = 38;
    localparam int HDR_PF_NUM_LSB     = 64;
    localparam int HDR_VF_NUM_LSB     = 67;
    localparam int HDR_VF_ACTIVE_BIT  = 75;
    localparam int HDR_ADDR64_LO_LSB  = 96;
    localparam int HDR_ADDR32_LSB     = 64;

    // Extra completion fields and the payload position on the bus
    localparam int CPL_BYTE_COUNT_LSB = 32;
    localparam int CPL_LOW_ADDR_LSB   = 96;
    localparam int CPL_COMP_ID_LSB    = 112;
    localparam int CPL_DATA_LSB       = 128;
    localparam int HDR_BYTES          = 16;

    // Format and type codes
    localparam fmt_type_t FMT_MRD32      = 8'h00;
    localparam fmt_type_t FMT_MRD64      = 8'h20;
    localparam fmt_type_t FMT_CPLD       = 8'h4A;
    localparam int        FMT_ADDR64_BIT = 5;

    // Feature header register map
    localparam logic [3:0] REG_IDX_DFH      = 4'h0;
    localparam logic [3:0] REG_IDX_AFU_ID_L = 4'h1;
    localparam logic [3:0] REG_IDX_AFU_ID_H = 4'h2;
    // Type accelerator, end of list
    localparam reg_data_t  DFH_VALUE        = 64'h1000_0100_0000_0000;
    localparam reg_data_t  AFU_ID_H_VALUE   = 64'hC0FF_EE01_0000_0000;

    // Request queue sizing
    localparam int REQ_QUEUE_DEPTH = 4;
    localparam int REQ_QUEUE_PTR_W = $clog2(REQ_QUEUE_DEPTH);
    localparam int REQ_QUEUE_CNT_W = $clog2(REQ_QUEUE_DEPTH + 1);

    // Fields the completion needs from one read request
    typedef struct packed {
        tlp_len_t  length;
        req_id_t   req_id;
        tlp_tag_t  tag;
        tc_t       tc;
        pf_num_t   pf_num;
        vf_num_t   vf_num;
        logic      vf_active;
        low_addr_t low_addr;
    } mmio_req_t;

endpackage

`default_nettype wire

/* src/mmio_req_if.sv */
// MMIO read request channel
// Valid/ready handshake carrying one decoded read request per transfer

`timescale 1ns/1ns
`default_nettype none

interface mmio_req_if;

    logic              valid;
    logic              ready;
    tlp_pkg::mmio_req_t req;

    // Producer side
    modport source
    (
        output valid,
        output req,
        input  ready
    );

    // Consumer side
    modport sink
    (
        input  valid,
        input  req,
        output ready
    );

endinterface

`default_nettype wire

/* src/mmio_req_decoder.sv */
// MMIO read request decoder
// Watches the RX TLP stream, drops everything except power-user memory
// reads and holds one decoded request until the queue takes it

`timescale 1ns/1ns
`default_nettype none

module mmio_req_decoder
(
    input  wire logic              clk,
    input  wire logic              reset_n,
    input  wire logic              rx_tvalid,
    output      logic              rx_tready,
    input  wire tlp_pkg::tlp_data_t rx_tdata,
    input  wire logic              rx_sop,
    input  wire logic              rx_dm_mode,
    mmio_req_if.source             req
);

    tlp_pkg::tlp_hdr_t  rx_hdr;
    tlp_pkg::fmt_type_t rx_fmt_type;
    logic [31:0]        addr_word;
    logic               is_mrd;
    logic               rx_take;
    logic               req_hit;
    logic               running;
    logic               out_valid;
    tlp_pkg::mmio_req_t dec_req;
    tlp_pkg::mmio_req_t out_req;

    // Header sits in the low bits of the SOP beat
    assign rx_hdr      = rx_tdata[$bits(tlp_pkg::tlp_hdr_t)-1:0];
    assign rx_fmt_type = rx_hdr[tlp_pkg::HDR_FMT_TYPE_LSB +: $bits(tlp_pkg::fmt_type_t)];
    assign is_mrd      = (rx_fmt_type == tlp_pkg::FMT_MRD32) ||
                         (rx_fmt_type == tlp_pkg::FMT_MRD64);

    // Room when the output register is empty or drains this cycle
    assign rx_tready = running && (!out_valid || req.ready);
    assign rx_take   = rx_tvalid && rx_tready;
    assign req_hit   = rx_take && rx_sop && !rx_dm_mode && is_mrd;

    always_comb
    begin
        // Address width bit picks which header word holds the low address
        if (rx_fmt_type[tlp_pkg::FMT_ADDR64_BIT])
        begin
            addr_word = rx_hdr[tlp_pkg::HDR_ADDR64_LO_LSB +: 32];
        end
        else
        begin
            addr_word = rx_hdr[tlp_pkg::HDR_ADDR32_LSB +: 32];
        end

        dec_req.length    = rx_hdr[tlp_pkg::HDR_LEN_LSB +: $bits(tlp_pkg::tlp_len_t)];
        dec_req.req_id    = rx_hdr[tlp_pkg::HDR_REQ_ID_LSB +: $bits(tlp_pkg::req_id_t)];
        dec_req.tag       = rx_hdr[tlp_pkg::HDR_TAG_LSB +: $bits(tlp_pkg::tlp_tag_t)];
        dec_req.tc        = rx_hdr[tlp_pkg::HDR_TC_LSB +: $bits(tlp_pkg::tc_t)];
        dec_req.pf_num    = rx_hdr[tlp_pkg::HDR_PF_NUM_LSB +: $bits(tlp_pkg::pf_num_t)];
        dec_req.vf_num    = rx_hdr[tlp_pkg::HDR_VF_NUM_LSB +: $bits(tlp_pkg::vf_num_t)];
        dec_req.vf_active = rx_hdr[tlp_pkg::HDR_VF_ACTIVE_BIT];
        // Dword aligned
        dec_req.low_addr  = {addr_word[6:2], 2'b00};
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            running   <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (req_hit)
            begin
                out_valid <= 1'b1;
            end
            else if (req.ready)
            begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (req_hit)
        begin
            out_req <= dec_req;
        end
    end

    assign req.valid = out_valid;
    assign req.req   = out_req;

endmodule

`default_nettype wire

/* src/mmio_req_queue.sv */
// MMIO read request queue
// Circular buffer between the decoder and the completion builder,
// one push and one pop per cycle

`timescale 1ns/1ns
`default_nettype none

module mmio_req_queue
(
    input  wire logic  clk,
    input  wire logic  reset_n,
    mmio_req_if.sink   in,
    mmio_req_if.source out
);

    localparam logic [tlp_pkg::REQ_QUEUE_PTR_W-1:0] LAST_PTR =
        tlp_pkg::REQ_QUEUE_PTR_W'(tlp_pkg::REQ_QUEUE_DEPTH - 1);
    localparam logic [tlp_pkg::REQ_QUEUE_CNT_W-1:0] FULL_CNT =
        tlp_pkg::REQ_QUEUE_CNT_W'(tlp_pkg::REQ_QUEUE_DEPTH);

    tlp_pkg::mmio_req_t                   mem [tlp_pkg::REQ_QUEUE_DEPTH];
    logic [tlp_pkg::REQ_QUEUE_PTR_W-1:0]  wr_ptr;
    logic [tlp_pkg::REQ_QUEUE_PTR_W-1:0]  rd_ptr;
    logic [tlp_pkg::REQ_QUEUE_CNT_W-1:0]  count;
    logic                                 push;
    logic                                 pop;

    assign in.ready  = (count != FULL_CNT);
    assign out.valid = (count != '0);
    assign out.req   = mem[rd_ptr];

    assign push = in.valid && in.ready;
    assign pop  = out.valid && out.ready;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            mem[wr_ptr] <= in.req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
            begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop)
            begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end

            // Simultaneous push and pop leaves the fill level alone
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/mmio_cpl_builder.sv */
// MMIO completion builder
// Turns each queued read request into a single-beat completion with
// data from the feature header register map

`timescale 1ns/1ns
`default_nettype none

module mmio_cpl_builder
(
    input  wire logic               clk,
    input  wire logic               reset_n,
    mmio_req_if.sink                req,
    output      logic               tx_tvalid,
    input  wire logic               tx_tready,
    output      tlp_pkg::tlp_data_t tx_tdata,
    output      tlp_pkg::tlp_keep_t tx_keep,
    output      logic               tx_last
);

    tlp_pkg::mmio_req_t r;
    tlp_pkg::tlp_hdr_t  cpl_hdr;
    tlp_pkg::reg_data_t cpl_data;
    tlp_pkg::tlp_keep_t cpl_keep;
    tlp_pkg::tlp_hdr_t  cpl_hdr_r;
    tlp_pkg::reg_data_t cpl_data_r;
    tlp_pkg::tlp_keep_t cpl_keep_r;
    logic               tx_valid_r;
    logic               take;

    assign r        = req.req;
    assign req.ready = !tx_valid_r || tx_tready;
    assign take     = req.valid && req.ready;

    always_comb
    begin
        cpl_hdr = '0;
        cpl_hdr[tlp_pkg::HDR_FMT_TYPE_LSB +: $bits(tlp_pkg::fmt_type_t)] = tlp_pkg::FMT_CPLD;
        cpl_hdr[tlp_pkg::HDR_LEN_LSB +: $bits(tlp_pkg::tlp_len_t)]       = r.length;
        cpl_hdr[tlp_pkg::HDR_REQ_ID_LSB +: $bits(tlp_pkg::req_id_t)]     = r.req_id;
        cpl_hdr[tlp_pkg::HDR_TAG_LSB +: $bits(tlp_pkg::tlp_tag_t)]       = r.tag;
        cpl_hdr[tlp_pkg::HDR_TC_LSB +: $bits(tlp_pkg::tc_t)]             = r.tc;
        // Byte count shares bits 43:38 with the tag and is written after it
        cpl_hdr[tlp_pkg::CPL_BYTE_COUNT_LSB +: $bits(tlp_pkg::byte_count_t)] =
            {r.length, 2'b00};
        cpl_hdr[tlp_pkg::CPL_LOW_ADDR_LSB +: $bits(tlp_pkg::low_addr_t)] = r.low_addr;
        // The PCIe subsystem maps PF/VF to the real completer ID
        cpl_hdr[tlp_pkg::CPL_COMP_ID_LSB +: $bits(tlp_pkg::req_id_t)] =
            {4'h0, r.vf_num, r.vf_active, r.pf_num};
        cpl_hdr[tlp_pkg::HDR_PF_NUM_LSB +: $bits(tlp_pkg::pf_num_t)] = r.pf_num;
        cpl_hdr[tlp_pkg::HDR_VF_NUM_LSB +: $bits(tlp_pkg::vf_num_t)] = r.vf_num;
        cpl_hdr[tlp_pkg::HDR_VF_ACTIVE_BIT]                          = r.vf_active;
    end

    // Register index is the 64-bit word offset
    always_comb
    begin
        case (r.low_addr[6:3])
            tlp_pkg::REG_IDX_DFH:
                cpl_data = tlp_pkg::DFH_VALUE;
            tlp_pkg::REG_IDX_AFU_ID_L:
            begin
                cpl_data        = '0;
                cpl_data[63:56] = r.vf_num;
                cpl_data[52]    = r.vf_active;
                cpl_data[51:48] = {1'b0, r.pf_num};
            end
            tlp_pkg::REG_IDX_AFU_ID_H:
                cpl_data = tlp_pkg::AFU_ID_H_VALUE;
            default:
                cpl_data = '0;
        endcase

        // Short read of the upper half returns it in the low dword
        if (r.low_addr[2])
        begin
            cpl_data[31:0] = cpl_data[63:32];
        end
    end

    // Header bytes plus 4 or 8 data bytes
    assign cpl_keep = tlp_pkg::tlp_keep_t'({{4{r.length != 10'd1}}, 4'hF,
                                            {tlp_pkg::HDR_BYTES{1'b1}}});

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            tx_valid_r <= 1'b0;
        end
        else if (take)
        begin
            tx_valid_r <= 1'b1;
        end
        else if (tx_tready)
        begin
            tx_valid_r <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (take)
        begin
            cpl_hdr_r  <= cpl_hdr;
            cpl_data_r <= cpl_data;
            cpl_keep_r <= cpl_keep;
        end
    end

    always_comb
    begin
        tx_tdata = '0;
        tx_tdata[$bits(tlp_pkg::tlp_hdr_t)-1:0] = cpl_hdr_r;
        tx_tdata[tlp_pkg::CPL_DATA_LSB +: $bits(tlp_pkg::reg_data_t)] = cpl_data_r;
    end

    assign tx_tvalid = tx_valid_r;
    assign tx_keep   = cpl_keep_r;
    // Every completion fits in one beat
    assign tx_last   = 1'b1;

endmodule

`default_nettype wire

/* src/mmio_tie_off_top.sv */
// MMIO tie-off endpoint
// Answers power-user MMIO reads from the host with a minimal feature
// header map in place of a missing accelerator

`timescale 1ns/1ns
`default_nettype none

module mmio_tie_off_top
(
    input  wire logic               clk,
    input  wire logic               reset_n,

    // RX stream from the host
    input  wire logic               rx_tvalid,
    output      logic               rx_tready,
    input  wire tlp_pkg::tlp_data_t rx_tdata,
    input  wire logic               rx_sop,
    input  wire logic               rx_eop,
    input  wire logic               rx_dm_mode,

    // TX stream to the host
    output      logic               tx_tvalid,
    input  wire logic               tx_tready,
    output      tlp_pkg::tlp_data_t tx_tdata,
    output      tlp_pkg::tlp_keep_t tx_keep,
    output      logic               tx_last
);

    mmio_req_if dec_to_queue();
    mmio_req_if queue_to_cpl();

    // Headers always arrive on SOP beats, so rx_eop is not needed
    mmio_req_decoder u_decoder
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx_tvalid  (rx_tvalid),
        .rx_tready  (rx_tready),
        .rx_tdata   (rx_tdata),
        .rx_sop     (rx_sop),
        .rx_dm_mode (rx_dm_mode),
        .req        (dec_to_queue.source)
    );

    mmio_req_queue u_queue
    (
        .clk     (clk),
        .reset_n (reset_n),
        .in      (dec_to_queue.sink),
        .out     (queue_to_cpl.source)
    );

    mmio_cpl_builder u_cpl_builder
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .req       (queue_to_cpl.sink),
        .tx_tvalid (tx_tvalid),
        .tx_tready (tx_tready),
        .tx_tdata  (tx_tdata),
        .tx_keep   (tx_keep),
        .tx_last   (tx_last)
    );

endmodule

`default_nettype wire

/* verif/tb_clock_gen.sv */
// Testbench clock and reset generator
// 20 ns clock, active-low reset held for the first 8 cycles

`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic reset_n
);

    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 8;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD_NS clk = ~clk;
    end

    // Release away from the rising edge so the synchronous reset is clean
    initial
    begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_mmio_tie_off.sv */
// Testbench for the MMIO tie-off endpoint
// Drives a table of TLP beats, models the expected completions and
// checks them under random and long TX back-pressure

`timescale 1ns/1ns
`default_nettype none

module tb_mmio_tie_off;

    localparam int          NUM_STIM          = 14;
    localparam int          RESET_WAIT_LIMIT  = 50;
    localparam int          IDLE_CHECK_CYCLES = 4;
    localparam int          RX_WAIT_LIMIT     = 200;
    localparam int          DRAIN_LIMIT       = 1000;
    localparam int          QUIET_CYCLES      = 20;
    localparam int          STALL_CYCLES      = 40;
    localparam logic [15:0] LFSR_SEED         = 16'd70;

    typedef struct packed {
        logic [7:0]  fmt;
        logic        dm_mode;
        logic        sop;
        logic        eop;
        logic [63:0] addr;
        logic [9:0]  len;
        logic [9:0]  tag;
        logic [15:0] req_id;
        logic [2:0]  tc;
        logic [2:0]  pf;
        logic [7:0]  vf;
        logic        vf_active;
        logic        expect_cpl;
    } stim_t;

    typedef struct packed {
        tlp_pkg::tlp_data_t data;
        tlp_pkg::tlp_keep_t keep;
    } cpl_t;

    logic               clk;
    logic               reset_n;
    logic               rx_tvalid;
    logic               rx_tready;
    tlp_pkg::tlp_data_t rx_tdata;
    logic               rx_sop;
    logic               rx_eop;
    logic               rx_dm_mode;
    logic               tx_tvalid;
    logic               tx_tready;
    tlp_pkg::tlp_data_t tx_tdata;
    tlp_pkg::tlp_keep_t tx_keep;
    logic               tx_last;

    stim_t       stim_table [NUM_STIM];
    cpl_t        expected_q [$];
    logic [15:0] lfsr_state;
    int          error_count;
    int          check_count;
    int          cpl_count;
    int          stall_cycles;
    logic        saw_rx_stall;
    logic        aborted;

    tb_clock_gen u_clock_gen
    (
        .clk     (clk),
        .reset_n (reset_n)
    );

    mmio_tie_off_top DUT
    (
        .clk        (clk),
        .reset_n    (reset_n),
        .rx_tvalid  (rx_tvalid),
        .rx_tready  (rx_tready),
        .rx_tdata   (rx_tdata),
        .rx_sop     (rx_sop),
        .rx_eop     (rx_eop),
        .rx_dm_mode (rx_dm_mode),
        .tx_tvalid  (tx_tvalid),
        .tx_tready  (tx_tready),
        .tx_tdata   (tx_tdata),
        .tx_keep    (tx_keep),
        .tx_last    (tx_last)
    );

    // Columns: fmt, dm, sop, eop, addr, len, tag, req_id, tc, pf, vf, vf_active, expect
    initial
    begin
        stim_table[0]  = '{8'h20, 1'b0, 1'b1, 1'b1, 64'h0000_0000_8000_0000, 10'd2,
                           10'h001, 16'h0100, 3'd0, 3'd0, 8'h00, 1'b0, 1'b1};
        stim_table[1]  = '{8'h20, 1'b0, 1'b1, 1'b1, 64'h0000_0001_8000_0008, 10'd2,
                           10'h2A5, 16'hBEEF, 3'd5, 3'd3, 8'h5A, 1'b1, 1'b1};
        stim_table[2]  = '{8'h20, 1'b0, 1'b1, 1'b1, 64'h0000_0000_8000_0010, 10'd2,
                           10'h3FF, 16'h1234, 3'd7, 3'd7, 8'hFF, 1'b1, 1'b1};
        stim_table[3]  = '{8'h20, 1'b0, 1'b1, 1'b1, 64'h0000_0000_8000_0018, 10'd2,
                           10'h100, 16'h0042, 3'd1, 3'd1, 8'h10, 1'b0, 1'b1};
        // 32-bit reads share the address word with pf/vf, so those columns match it
        stim_table[4]  = '{8'h00, 1'b0, 1'b1, 1'b1, 64'h0000_0000_0000_0000, 10'd2,
                           10'h055, 16'h2001, 3'd2, 3'd0, 8'h00, 1'b0, 1'b1};
        stim_table[5]  = '{8'h00, 1'b0, 1'b1, 1'b1, 64'h0000_0000_0000_0008, 10'd2,
                           10'h0AA, 16'h2002, 3'd3, 3'd0, 8'h01, 1'b0, 1'b1};
        stim_table[6]  = '{8'h00, 1'b0, 1'b1, 1'b1, 64'h0000_0000_0000_0050, 10'd2,
                           10'h123, 16'h2003, 3'd4, 3'd0, 8'h0A, 1'b0, 1'b1};
        // One-dword reads of the upper half
        stim_table[7]  = '{8'h20, 1'b0, 1'b1, 1'b1, 64'h0000_0000_8000_000C, 10'd1,
                           10'h321, 16'h3001, 3'd6, 3'd2, 8'h33, 1'b1, 1'b1};
        stim_table[8]  = '{8'h00, 1'b0, 1'b1, 1'b1, 64'h0000_0000_0000_0014, 10'd1,
                           10'h0F0, 16'h3002, 3'd0, 3'd4, 8'h02, 1'b0, 1'b1};
        // Two-beat write, then its payload beat that looks like a read header
        stim_table[9]  = '{8'h60, 1'b0, 1'b1, 1'b0, 64'h0000_0000_8000_0000, 10'd1,
                           10'h011, 16'h4001, 3'd0, 3'd0, 8'h00, 1'b0, 1'b0};
        stim_table[10] = '{8'h20, 1'b0, 1'b0, 1'b1, 64'h0000_0000_8000_0008, 10'd2,
                           10'h012, 16'h4002, 3'd0, 3'd0, 8'h00, 1'b0, 1'b0};
        stim_table[11] = '{8'h20, 1'b1, 1'b1, 1'b1, 64'h0000_0000_8000_0000, 10'd2,
                           10'h013, 16'h4003, 3'd0, 3'd1, 8'h00, 1'b0, 1'b0};
        stim_table[12] = '{8'h40, 1'b0, 1'b1, 1'b1, 64'h0000_0000_0000_0000, 10'd1,
                           10'h014, 16'h4004, 3'd0, 3'd0, 8'h00, 1'b0, 1'b0};
        stim_table[13] = '{8'h20, 1'b0, 1'b1, 1'b1, 64'h0000_0000_8000_0004, 10'd1,
                           10'h3FE, 16'hFFFF, 3'd7, 3'd5, 8'h81, 1'b1, 1'b1};
    end

    // Fibonacci LFSR, taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic next_random_bit(output logic b);
        lfsr_state = lfsr_next(lfsr_state);
        b = lfsr_state[0];
    endtask

    // Address goes in first, pf/vf fields are laid over the word they share
    function automatic tlp_pkg::tlp_hdr_t build_header(input stim_t s);
        tlp_pkg::tlp_hdr_t h;
        h = '0;
        if (s.fmt[5])
        begin
            h[95:64]  = s.addr[63:32];
            h[127:96] = s.addr[31:0];
        end
        else
        begin
            h[95:64] = s.addr[31:0];
        end
        h[31:24] = s.fmt;
        h[9:0]   = s.len;
        h[22:20] = s.tc;
        h[63:48] = s.req_id;
        h[47:38] = s.tag;
        h[66:64] = s.pf;
        h[74:67] = s.vf;
        h[75]    = s.vf_active;
        return h;
    endfunction

    // Reference completion for one read header
    function automatic cpl_t expected_completion(input tlp_pkg::tlp_hdr_t h);
        cpl_t               c;
        tlp_pkg::tlp_hdr_t  hdr;
        tlp_pkg::reg_data_t data;
        logic [7:0]         fmt;
        logic [31:0]        addr_word;
        logic [6:0]         low_addr;
        logic [9:0]         len;
        fmt       = h[31:24];
        len       = h[9:0];
        addr_word = fmt[5] ? h[127:96] : h[95:64];
        low_addr  = {addr_word[6:2], 2'b00};

        hdr          = '0;
        hdr[31:24]   = 8'h4A;
        hdr[9:0]     = len;
        hdr[63:48]   = h[63:48];
        hdr[47:38]   = h[47:38];
        hdr[22:20]   = h[22:20];
        // Byte count owns bits 43:38 where it overlaps the tag
        hdr[43:32]   = 12'(len) * 12'd4;
        hdr[102:96]  = low_addr;
        hdr[127:112] = {4'h0, h[74:67], h[75], h[66:64]};
        hdr[75:64]   = h[75:64];

        case (low_addr[6:3])
            4'h0:    data = 64'h1000_0100_0000_0000;
            4'h1:    data = {h[74:67], 3'b000, h[75], 1'b0, h[66:64], 48'h0};
            4'h2:    data = 64'hC0FF_EE01_0000_0000;
            default: data = '0;
        endcase
        if (low_addr[2])
        begin
            data[31:0] = data[63:32];
        end

        c.data = {64'h0, data, hdr};
        c.keep = (len == 10'd1) ? 32'h000F_FFFF : 32'h00FF_FFFF;
        return c;
    endfunction

    task automatic check_value(input string name, input logic [255:0] actual,
                               input logic [255:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected);
        end
    endtask

    // One RX beat, held until the DUT is ready
    task automatic drive_beat(input int idx);
        stim_t             s;
        tlp_pkg::tlp_hdr_t hdr;
        int                waited;
        s      = stim_table[idx];
        hdr    = build_header(s);
        waited = 0;
        @(negedge clk);
        rx_tdata   = {{4{32'hDA7A_0000 | 32'(idx)}}, hdr};
        rx_sop     = s.sop;
        rx_eop     = s.eop;
        rx_dm_mode = s.dm_mode;
        rx_tvalid  = 1'b1;
        if (s.expect_cpl)
        begin
            expected_q.push_back(expected_completion(hdr));
        end
        while (!rx_tready && waited < RX_WAIT_LIMIT)
        begin
            saw_rx_stall = 1'b1;
            @(negedge clk);
            waited++;
        end
        if (!rx_tready)
        begin
            error_count++;
            aborted = 1'b1;
            $display("Timeout: rx_tready stayed low for %0d cycles on entry %0d", waited, idx);
        end
    endtask

    task automatic idle_rx();
        @(negedge clk);
        rx_tvalid  = 1'b0;
        rx_sop     = 1'b0;
        rx_eop     = 1'b0;
        rx_dm_mode = 1'b0;
    endtask

    // TX back-pressure and completion monitor, from the first rising edge on
    initial
    begin : tx_side
        logic b0;
        logic b1;
        cpl_t exp_cpl;
        @(posedge clk);
        forever
        begin
            @(negedge clk);
            if (stall_cycles > 0)
            begin
                tx_tready = 1'b0;
                stall_cycles--;
            end
            else
            begin
                next_random_bit(b0);
                next_random_bit(b1);
                tx_tready = b0 | b1;
            end

            // Transfer happens on the coming rising edge
            if (tx_tvalid && tx_tready)
            begin
                if (expected_q.size() == 0)
                begin
                    error_count++;
                    $display("Completion %0d arrived with no read request pending",
                             cpl_count);
                end
                else
                begin
                    exp_cpl = expected_q.pop_front();
                    check_value("tx_tdata[127:0]", 256'(tx_tdata[127:0]),
                                256'(exp_cpl.data[127:0]));
                    check_value("tx_tdata[191:128]", 256'(tx_tdata[191:128]),
                                256'(exp_cpl.data[191:128]));
                    check_value("tx_tdata[255:192]", 256'(tx_tdata[255:192]),
                                256'(exp_cpl.data[255:192]));
                    check_value("tx_keep", 256'(tx_keep), 256'(exp_cpl.keep));
                    check_value("tx_last", 256'(tx_last), 256'(1'b1));
                end
                cpl_count++;
            end
        end
    end

    initial
    begin : main
        int waited;
        rx_tvalid    = 1'b0;
        rx_tdata     = '0;
        rx_sop       = 1'b0;
        rx_eop       = 1'b0;
        rx_dm_mode   = 1'b0;
        tx_tready    = 1'b0;
        lfsr_state   = LFSR_SEED;
        error_count  = 0;
        check_count  = 0;
        cpl_count    = 0;
        stall_cycles = 0;
        saw_rx_stall = 1'b0;
        aborted      = 1'b0;

        // Nothing moves while reset is held
        waited = 0;
        @(posedge clk);
        @(negedge clk);
        while (!reset_n && waited < RESET_WAIT_LIMIT)
        begin
            check_value("rx_tready", 256'(rx_tready), 256'(1'b0));
            check_value("tx_tvalid", 256'(tx_tvalid), 256'(1'b0));
            @(negedge clk);
            waited++;
        end
        if (!reset_n)
        begin
            error_count++;
            aborted = 1'b1;
            $display("Timeout: reset was never released");
        end

        for (int i = 0; i < IDLE_CHECK_CYCLES; i++)
        begin
            @(negedge clk);
            check_value("tx_tvalid", 256'(tx_tvalid), 256'(1'b0));
        end

        // Whole table under random back-pressure
        for (int i = 0; i < NUM_STIM; i++)
        begin
            if (!aborted)
            begin
                drive_beat(i);
            end
        end
        idle_rx();

        // All reads again behind a long TX stall
        saw_rx_stall = 1'b0;
        @(posedge clk);
        stall_cycles = STALL_CYCLES;
        for (int i = 0; i < NUM_STIM; i++)
        begin
            if (!aborted && stim_table[i].expect_cpl)
            begin
                drive_beat(i);
            end
        end
        idle_rx();
        if (!saw_rx_stall)
        begin
            error_count++;
            $display("rx_tready never dropped while the TX side was stalled");
        end

        waited = 0;
        while (expected_q.size() > 0 && waited < DRAIN_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (expected_q.size() > 0)
        begin
            error_count++;
            $display("Timeout: %0d completions never arrived", expected_q.size());
        end

        // Watch for stray completions after the last one
        repeat (QUIET_CYCLES) @(negedge clk);

        $display("checks=%0d completions=%0d errors=%0d", check_count, cpl_count, error_count);
        if (error_count == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
src/tlp_pkg.sv
src/mmio_req_if.sv
src/mmio_req_decoder.sv
src/mmio_req_queue.sv
src/mmio_cpl_builder.sv
src/mmio_tie_off_top.sv
verif/tb_clock_gen.sv
verif/tb_mmio_tie_off.sv

/* run.sh */
#!/bin/sh
# Build the MMIO tie-off testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_mmio_tie_off

verilator --binary --timing -f all.f --top-module "$TOP" -o sim_"$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test OK" "$LOG"; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed, see $LOG"
    exit 1
fi
